/* logic/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and register file geometry
`define WORD_W 32
`define REG_W 5

// destination of JAL
`define LINK_REG 31

// busy cycles of the multiplier / divider
`define MULDIV_CYCLES 8

`endif

/* logic/isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,   // signed compare
        ALU_SLL,
        ALU_LUI,
        ALU_LINK   // pc + 8
    } aluOpE;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP
    } branchE;

    typedef enum logic [1:0] {
        MD_NONE,
        MD_MULTU,
        MD_DIVU
    } mulDivE;

endpackage

`default_nettype wire

/* logic/pipePkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package pipePkg;

    typedef logic [`WORD_W-1:0] wordT;
    typedef logic [`REG_W-1:0]  regIdxT;

    // where an operand comes from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwdSelE;

endpackage

`default_nettype wire

/* logic/decodedBus.sv */
`default_nettype none

interface decodedBus;

    logic             valid;
    pipePkg::wordT    pc;
    pipePkg::wordT    busA;
    pipePkg::wordT    busB;
    pipePkg::wordT    imm;
    pipePkg::regIdxT  rs;
    pipePkg::regIdxT  rt;
    pipePkg::regIdxT  dst;
    logic [4:0]       shamt;
    isaPkg::aluOpE    aluOp;
    logic             useImm;    // alu b from imm
    logic             regWrite;
    isaPkg::branchE   branch;
    logic [25:0]      jumpTarget;
    isaPkg::mulDivE   mulDiv;

    modport src (
        output valid, pc, busA, busB, imm, rs, rt, dst, shamt,
        output aluOp, useImm, regWrite, branch, jumpTarget, mulDiv
    );

    modport snk (
        input valid, pc, busA, busB, imm, rs, rt, dst, shamt,
        input aluOp, useImm, regWrite, branch, jumpTarget, mulDiv
    );

endinterface

`default_nettype wire

/* logic/instrDecoder.sv */
`default_nettype none

`include "cpu_consts.svh"

module instrDecoder (
    input  pipePkg::wordT instr,
    input  pipePkg::wordT pc,
    input  pipePkg::wordT busA,
    input  pipePkg::wordT busB,
    decodedBus.src        out
);

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic [5:0]      opcode;
    logic [5:0]      funct;
    pipePkg::regIdxT rd;
    pipePkg::wordT   immSext;
    pipePkg::wordT   immZext;
    logic            known;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rd      = instr[15:11];
    assign immSext = {{16{instr[15]}}, instr[15:0]};
    assign immZext = {16'b0, instr[15:0]};

    assign out.pc         = pc;
    assign out.busA       = busA;
    assign out.busB       = busB;
    assign out.rs         = instr[25:21];
    assign out.rt         = instr[20:16];
    assign out.shamt      = instr[10:6];
    assign out.jumpTarget = instr[25:0];

    always_comb begin
        known        = 1'b1;
        out.aluOp    = isaPkg::ALU_ADD;
        out.useImm   = 1'b0;
        out.regWrite = 1'b1;
        out.branch   = isaPkg::BR_NONE;
        out.mulDiv   = isaPkg::MD_NONE;
        out.dst      = rd;
        out.imm      = immSext;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: out.aluOp = isaPkg::ALU_ADD;
                    FN_SUBU: out.aluOp = isaPkg::ALU_SUB;
                    FN_AND:  out.aluOp = isaPkg::ALU_AND;
                    FN_OR:   out.aluOp = isaPkg::ALU_OR;
                    FN_XOR:  out.aluOp = isaPkg::ALU_XOR;
                    FN_SLT:  out.aluOp = isaPkg::ALU_SLT;
                    FN_SLL:  out.aluOp = isaPkg::ALU_SLL;
                    FN_MULTU: begin
                        out.regWrite = 1'b0;
                        out.mulDiv   = isaPkg::MD_MULTU;
                    end
                    FN_DIVU: begin
                        out.regWrite = 1'b0;
                        out.mulDiv   = isaPkg::MD_DIVU;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                out.useImm = 1'b1;
                out.dst    = out.rt;
            end
            OP_ORI: begin
                out.aluOp  = isaPkg::ALU_OR;
                out.useImm = 1'b1;
                out.dst    = out.rt;
                out.imm    = immZext;
            end
            OP_LUI: begin
                out.aluOp  = isaPkg::ALU_LUI;
                out.useImm = 1'b1;
                out.dst    = out.rt;
                out.imm    = immZext;
            end
            OP_BEQ: begin
                out.regWrite = 1'b0;
                out.branch   = isaPkg::BR_EQ;
            end
            OP_BNE: begin
                out.regWrite = 1'b0;
                out.branch   = isaPkg::BR_NE;
            end
            OP_JAL: begin
                out.aluOp  = isaPkg::ALU_LINK;
                out.branch = isaPkg::BR_JUMP;
                out.dst    = pipePkg::regIdxT'(`LINK_REG);
            end
            default: known = 1'b0;
        endcase
        if (!known) begin  // bubble
            out.regWrite = 1'b0;
            out.branch   = isaPkg::BR_NONE;
            out.mulDiv   = isaPkg::MD_NONE;
        end
        out.valid = known;
    end

endmodule

`default_nettype wire

/* logic/idExeReg.sv */
`default_nettype none

module idExeReg (
    input  logic   clk,
    input  logic   rst,
    input  logic   exeWr,
    input  logic   exeFlush,
    decodedBus.snk in,
    decodedBus.src out,
    output logic   issue
);

    logic clear;

    assign clear = rst || exeFlush;  // flush wins over load

    always_ff @(posedge clk) begin
        if (clear) begin
            out.valid    <= 1'b0;
            out.regWrite <= 1'b0;
            out.branch   <= isaPkg::BR_NONE;
            out.mulDiv   <= isaPkg::MD_NONE;
        end else if (exeWr) begin
            out.valid    <= in.valid;
            out.regWrite <= in.regWrite;
            out.branch   <= in.branch;
            out.mulDiv   <= in.mulDiv;
        end
    end

    always_ff @(posedge clk) begin
        if (exeWr) begin
            out.pc         <= in.pc;
            out.busA       <= in.busA;
            out.busB       <= in.busB;
            out.imm        <= in.imm;
            out.rs         <= in.rs;
            out.rt         <= in.rt;
            out.dst        <= in.dst;
            out.shamt      <= in.shamt;
            out.aluOp      <= in.aluOp;
            out.useImm     <= in.useImm;
            out.jumpTarget <= in.jumpTarget;
        end
    end

    // one pulse per loaded instruction even for back to back copies
    always_ff @(posedge clk) begin
        if (clear) begin
            issue <= 1'b0;
        end else begin
            issue <= exeWr && in.valid;
        end
    end

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
`default_nettype none

module executeUnit (
    decodedBus.snk          in,
    input  logic            memRegWrite,
    input  pipePkg::regIdxT memDst,
    input  pipePkg::wordT   memResult,
    input  logic            wbRegWrite,
    input  pipePkg::regIdxT wbDst,
    input  pipePkg::wordT   wbResult,
    output pipePkg::wordT   aluOut,
    output pipePkg::regIdxT exeDst,
    output logic            exeRegWrite,
    output logic            branchTaken,
    output pipePkg::wordT   branchTarget,
    output pipePkg::wordT   fwdA,
    output pipePkg::wordT   fwdB
);

    pipePkg::fwdSelE selA;
    pipePkg::fwdSelE selB;
    pipePkg::wordT   aluA;
    pipePkg::wordT   aluB;
    pipePkg::wordT   pcPlus4;
    logic            condMet;

    function automatic pipePkg::fwdSelE fwdSource(
        input pipePkg::regIdxT src,
        input logic            memHit,
        input logic            wbHit
    );
        if (src == '0) begin
            return pipePkg::FWD_REG;  // r0 stays zero
        end else if (memHit) begin
            return pipePkg::FWD_MEM;
        end else if (wbHit) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_REG;
    endfunction

    assign selA = fwdSource(in.rs, memRegWrite && (memDst == in.rs),
                            wbRegWrite && (wbDst == in.rs));
    assign selB = fwdSource(in.rt, memRegWrite && (memDst == in.rt),
                            wbRegWrite && (wbDst == in.rt));

    assign fwdA = (selA == pipePkg::FWD_MEM) ? memResult :
                  (selA == pipePkg::FWD_WB)  ? wbResult  : in.busA;
    assign fwdB = (selB == pipePkg::FWD_MEM) ? memResult :
                  (selB == pipePkg::FWD_WB)  ? wbResult  : in.busB;

    assign aluA = (in.aluOp == isaPkg::ALU_SLL) ? pipePkg::wordT'(in.shamt) : fwdA;
    assign aluB = in.useImm ? in.imm : fwdB;

    always_comb begin
        case (in.aluOp)
            isaPkg::ALU_ADD:  aluOut = aluA + aluB;
            isaPkg::ALU_SUB:  aluOut = aluA - aluB;
            isaPkg::ALU_AND:  aluOut = aluA & aluB;
            isaPkg::ALU_OR:   aluOut = aluA | aluB;
            isaPkg::ALU_XOR:  aluOut = aluA ^ aluB;
            isaPkg::ALU_SLT:  aluOut = pipePkg::wordT'($signed(aluA) < $signed(aluB));
            isaPkg::ALU_SLL:  aluOut = aluB << aluA[4:0];
            isaPkg::ALU_LUI:  aluOut = {aluB[15:0], 16'b0};
            isaPkg::ALU_LINK: aluOut = in.pc + pipePkg::wordT'(8);
            default:          aluOut = aluA + aluB;
        endcase
    end

    assign exeDst      = in.dst;
    assign exeRegWrite = in.valid && in.regWrite;

    assign pcPlus4 = in.pc + pipePkg::wordT'(4);

    always_comb begin
        case (in.branch)
            isaPkg::BR_EQ:   condMet = (fwdA == fwdB);
            isaPkg::BR_NE:   condMet = (fwdA != fwdB);
            isaPkg::BR_JUMP: condMet = 1'b1;
            default:         condMet = 1'b0;
        endcase
    end

    assign branchTaken  = in.valid && condMet;
    assign branchTarget = (in.branch == isaPkg::BR_JUMP) ?
                          {pcPlus4[31:28], in.jumpTarget, 2'b00} :
                          pcPlus4 + {in.imm[29:0], 2'b00};

endmodule

`default_nettype wire

/* logic/mulDivUnit.sv */
`default_nettype none

`include "cpu_consts.svh"

module mulDivUnit (
    input  logic          clk,
    input  logic          rst,
    input  logic          issue,
    decodedBus.snk        in,
    input  pipePkg::wordT opA,
    input  pipePkg::wordT opB,
    input  logic          cancel,
    output pipePkg::wordT hi,
    output pipePkg::wordT lo,
    output logic          done,
    output logic          stall
);

    localparam int W     = `WORD_W;
    localparam int STEP  = `WORD_W / `MULDIV_CYCLES;  // bits per cycle
    localparam int CNT_W = $clog2(`MULDIV_CYCLES);

    typedef enum logic [1:0] {IDLE, BUSY, DONE} stateE;

    stateE            state;
    logic [CNT_W-1:0] count;
    isaPkg::mulDivE   op;
    pipePkg::wordT    operand;  // multiplicand or divisor
    logic [2*W-1:0]   acc;
    logic [2*W-1:0]   accNext;
    logic [2*W-1:0]   work;
    logic [W:0]       upper;
    logic [W-1:0]     lower;
    logic             start;
    logic             lastCycle;
    logic             finish;

    assign start     = issue && (in.mulDiv != isaPkg::MD_NONE);
    assign lastCycle = (count == CNT_W'(`MULDIV_CYCLES - 1));
    assign finish    = (state == BUSY) && lastCycle && !(rst || cancel || start);
    assign stall     = (state == BUSY);
    assign done      = (state == DONE);

    // STEP radix-2 iterations per clock
    always_comb begin
        work  = acc;
        upper = '0;
        lower = '0;
        for (int i = 0; i < STEP; i++) begin
            if (op == isaPkg::MD_MULTU) begin
                upper = {1'b0, work[2*W-1:W]} + (work[0] ? {1'b0, operand} : '0);
                work  = {upper, work[W-1:1]};
            end else begin
                upper = work[2*W-1:W-1];  // partial remainder shifted
                lower = {work[W-2:0], 1'b0};
                if (upper >= {1'b0, operand}) begin
                    upper    = upper - {1'b0, operand};
                    lower[0] = 1'b1;
                end
                work = {upper[W-1:0], lower};
            end
        end
        accNext = work;
    end

    always_ff @(posedge clk) begin
        if (rst || cancel) begin
            state <= IDLE;
            count <= '0;
        end else if (start) begin
            state <= BUSY;
            count <= '0;
        end else begin
            case (state)
                BUSY: begin
                    count <= count + CNT_W'(1);
                    if (lastCycle) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op      <= in.mulDiv;
            operand <= (in.mulDiv == isaPkg::MD_MULTU) ? opA : opB;
            acc     <= {{W{1'b0}}, (in.mulDiv == isaPkg::MD_MULTU) ? opB : opA};
        end else if (state == BUSY) begin
            acc <= accNext;
        end
        if (finish) begin  // quotient lands in lo, remainder in hi
            hi <= accNext[2*W-1:W];
            lo <= accNext[W-1:0];
        end
    end

endmodule

`default_nettype wire

/* logic/exeStage.sv */
`default_nettype none

module exeStage (
    input  logic            clk,
    input  logic            rst,
    input  pipePkg::wordT   instr,
    input  pipePkg::wordT   pc,
    input  pipePkg::wordT   busA,
    input  pipePkg::wordT   busB,
    input  logic            exeWr,
    input  logic            exeFlush,
    input  logic            memRegWrite,
    input  pipePkg::regIdxT memDst,
    input  pipePkg::wordT   memResult,
    input  logic            wbRegWrite,
    input  pipePkg::regIdxT wbDst,
    input  pipePkg::wordT   wbResult,
    input  logic            mulDivCancel,
    output pipePkg::wordT   aluOut,
    output pipePkg::regIdxT exeDst,
    output logic            exeRegWrite,
    output logic            branchTaken,
    output pipePkg::wordT   branchTarget,
    output pipePkg::wordT   hi,
    output pipePkg::wordT   lo,
    output logic            mulDivDone,
    output logic            mulDivStall
);

    logic          issue;
    pipePkg::wordT fwdA;
    pipePkg::wordT fwdB;

    decodedBus decBus ();
    decodedBus exeBus ();

    instrDecoder uInstrDecoder (
        .instr (instr),
        .pc    (pc),
        .busA  (busA),
        .busB  (busB),
        .out   (decBus.src)
    );

    idExeReg uIdExeReg (
        .clk      (clk),
        .rst      (rst),
        .exeWr    (exeWr),
        .exeFlush (exeFlush),
        .in       (decBus.snk),
        .out      (exeBus.src),
        .issue    (issue)
    );

    executeUnit uExecuteUnit (
        .in           (exeBus.snk),
        .memRegWrite  (memRegWrite),
        .memDst       (memDst),
        .memResult    (memResult),
        .wbRegWrite   (wbRegWrite),
        .wbDst        (wbDst),
        .wbResult     (wbResult),
        .aluOut       (aluOut),
        .exeDst       (exeDst),
        .exeRegWrite  (exeRegWrite),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .fwdA         (fwdA),
        .fwdB         (fwdB)
    );

    // operands taken after forwarding
    mulDivUnit uMulDivUnit (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .in     (exeBus.snk),
        .opA    (fwdA),
        .opB    (fwdB),
        .cancel (mulDivCancel),
        .hi     (hi),
        .lo     (lo),
        .done   (mulDivDone),
        .stall  (mulDivStall)
    );

endmodule

`default_nettype wire

/* testbench/exeStageTb.sv */
`default_nettype none

`include "cpu_consts.svh"

module exeStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 4 * `MULDIV_CYCLES;
    localparam logic [41:0] R_FUNCTS = {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00};
    localparam logic [17:0] I_OPS    = {6'h09, 6'h0d, 6'h0f};  // addiu ori lui

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] busA;
    logic [31:0] busB;
    logic        exeWr;
    logic        exeFlush;
    logic        memRegWrite;
    logic [4:0]  memDst;
    logic [31:0] memResult;
    logic        wbRegWrite;
    logic [4:0]  wbDst;
    logic [31:0] wbResult;
    logic        mulDivCancel;
    logic [31:0] aluOut;
    logic [4:0]  exeDst;
    logic        exeRegWrite;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic [31:0] hi;
    logic [31:0] lo;
    logic        mulDivDone;
    logic        mulDivStall;

    // forwarding sources seen by the instruction in exe
    logic        fMemWr;
    logic [4:0]  fMemDst;
    logic [31:0] fMemRes;
    logic        fWbWr;
    logic [4:0]  fWbDst;
    logic [31:0] fWbRes;

    // reference model state
    logic [31:0] expAlu;
    logic [4:0]  expDst;
    logic        expRegWrite = 1'b0;
    logic        expTaken = 1'b0;
    logic        expBranch = 1'b0;
    logic [31:0] expTarget;
    logic        expStall = 1'b0;
    logic        expDone = 1'b0;
    logic        hiLoKnown = 1'b0;
    logic [31:0] expHi;
    logic [31:0] expLo;

    int errors = 0;
    int timeouts = 0;
    int seed = 32'h16b8bfa7;

    exeStage uut (.*);

    always #4 clk = ~clk;

    resetClear: assert property (@(negedge clk)
        !rst || (!exeRegWrite && !branchTaken && !mulDivStall && !mulDivDone))
        else begin
            errors = errors + 1;
            $display("FAIL at %0t: outputs not cleared during reset", $time);
        end

    regWriteOk: assert property (@(negedge clk) exeRegWrite == expRegWrite)
        else begin
            errors = errors + 1;
            $display("FAIL at %0t: exeRegWrite %0b, expected %0b", $time, exeRegWrite,
                     expRegWrite);
        end

    resultOk: assert property (@(negedge clk)
        !expRegWrite || (aluOut == expAlu && exeDst == expDst))
        else begin
            errors = errors + 1;
            $display("FAIL at %0t: aluOut %h dst %0d, expected %h dst %0d", $time, aluOut,
                     exeDst, expAlu, expDst);
        end

    branchOk: assert property (@(negedge clk)
        branchTaken == expTaken && (!expBranch || branchTarget == expTarget))
        else begin
            errors = errors + 1;
            $display("FAIL at %0t: taken %0b target %h, expected %0b %h", $time, branchTaken,
                     branchTarget, expTaken, expTarget);
        end

    mulDivFlagsOk: assert property (@(negedge clk)
        mulDivStall == expStall && mulDivDone == expDone)
        else begin
            errors = errors + 1;
            $display("FAIL at %0t: stall %0b done %0b, expected %0b %0b", $time, mulDivStall,
                     mulDivDone, expStall, expDone);
        end

    hiLoOk: assert property (@(negedge clk) !hiLoKnown || (hi == expHi && lo == expLo))
        else begin
            errors = errors + 1;
            $display("FAIL at %0t: hi %h lo %h, expected %h %h", $time, hi, lo, expHi, expLo);
        end

    function automatic logic [31:0] rType(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // mem beats wb and r0 is never forwarded
    function automatic logic [31:0] fwdValue(input logic [4:0] r, input logic [31:0] regVal);
        if (r == 5'd0) begin
            return regVal;
        end else if (fMemWr && fMemDst == r) begin
            return fMemRes;
        end else if (fWbWr && fWbDst == r) begin
            return fWbRes;
        end
        return regVal;
    endfunction

    task automatic predict(input logic [31:0] ins, input logic [31:0] p,
                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] sImm;
        logic [31:0] pc4;
        sImm = {{16{ins[15]}}, ins[15:0]};
        pc4 = p + 32'd4;
        expRegWrite = 1'b1;
        expTaken = 1'b0;
        expBranch = 1'b0;
        expDst = ins[20:16];
        expAlu = '0;
        expTarget = '0;
        case (ins[31:26])
            6'h00: begin
                expDst = ins[15:11];
                case (ins[5:0])
                    6'h21: expAlu = a + b;
                    6'h23: expAlu = a - b;
                    6'h24: expAlu = a & b;
                    6'h25: expAlu = a | b;
                    6'h26: expAlu = a ^ b;
                    6'h2a: expAlu = {31'b0, $signed(a) < $signed(b)};
                    6'h00: expAlu = b << ins[10:6];
                    default: expRegWrite = 1'b0;  // multu, divu, unknown
                endcase
            end
            6'h09: expAlu = a + sImm;
            6'h0d: expAlu = a | {16'h0, ins[15:0]};
            6'h0f: expAlu = {ins[15:0], 16'h0};
            6'h04, 6'h05: begin
                expRegWrite = 1'b0;
                expBranch = 1'b1;
                expTaken = ins[26] ? (a != b) : (a == b);  // bne has opcode bit 0 set
                expTarget = pc4 + {sImm[29:0], 2'b00};
            end
            6'h03: begin
                expDst = 5'(`LINK_REG);
                expAlu = p + 32'd8;
                expTaken = 1'b1;
                expBranch = 1'b1;
                expTarget = {pc4[31:28], ins[25:0], 2'b00};
            end
            default: expRegWrite = 1'b0;
        endcase
    endtask

    task automatic issueFwd(input logic [31:0] ins, input logic [31:0] a,
                            input logic [31:0] b, input logic mw, input logic [4:0] md,
                            input logic [31:0] mr, input logic ww, input logic [4:0] wd,
                            input logic [31:0] wr);
        logic [31:0] p;
        p = $random(seed) & 32'hffff_fffc;
        @(posedge clk);
        instr <= ins;
        pc <= p;
        busA <= a;
        busB <= b;
        exeWr <= 1'b1;
        @(posedge clk);  // load edge where mem/wb switch too
        exeWr <= 1'b0;
        fMemWr = mw;
        fMemDst = md;
        fMemRes = mr;
        fWbWr = ww;
        fWbDst = wd;
        fWbRes = wr;
        memRegWrite <= mw;
        memDst <= md;
        memResult <= mr;
        wbRegWrite <= ww;
        wbDst <= wd;
        wbResult <= wr;
        predict(ins, p, fwdValue(ins[25:21], a), fwdValue(ins[20:16], b));
    endtask

    task automatic issueInstr(input logic [31:0] ins, input logic [31:0] a,
                              input logic [31:0] b);
        issueFwd(ins, a, b, 1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
    endtask

    // new inputs without a load keep the outputs steady
    task automatic holdCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            instr <= $random(seed);
            busA <= $random(seed);
            busB <= $random(seed);
        end
    endtask

    task automatic flushInstr(input logic [31:0] ins);
        @(posedge clk);
        instr <= ins;
        exeWr <= 1'b1;
        exeFlush <= 1'b1;
        @(posedge clk);
        exeWr <= 1'b0;
        exeFlush <= 1'b0;
        expRegWrite = 1'b0;
        expTaken = 1'b0;
        expBranch = 1'b0;
    endtask

    task automatic runMulDiv(input logic [31:0] ins, input logic [31:0] a,
                             input logic [31:0] b, input int cancelAt);
        logic [63:0] prod;
        int t;
        issueInstr(ins, a, b);
        @(posedge clk);  // issue seen here
        expStall = 1'b1;
        if (cancelAt > 0) begin
            repeat (cancelAt - 1) @(posedge clk);
            mulDivCancel <= 1'b1;
            @(posedge clk);
            mulDivCancel <= 1'b0;
            expStall = 1'b0;
            repeat (`MULDIV_CYCLES + 2) @(posedge clk);
        end else begin
            repeat (`MULDIV_CYCLES) @(posedge clk);
            expStall = 1'b0;
            expDone = 1'b1;
            hiLoKnown = 1'b1;
            prod = {32'h0, a} * {32'h0, b};
            if (ins[5:0] == 6'h19) begin
                expHi = prod[63:32];
                expLo = prod[31:0];
            end else if (b == 32'd0) begin
                expHi = a;
                expLo = 32'hffff_ffff;
            end else begin
                expHi = a % b;
                expLo = a / b;
            end
            for (t = 0; t < TIMEOUT && !mulDivDone; t++) begin
                @(negedge clk);
            end
            if (!mulDivDone) begin
                timeouts = timeouts + 1;
                $display("timeout: mul/div unit never raised done");
            end
            @(posedge clk);
            expDone = 1'b0;
        end
    endtask

    initial begin
        int r;
        int k;
        logic [31:0] a;
        rst = 1'b1;
        instr = '0;
        pc = '0;
        busA = '0;
        busB = '0;
        exeWr = 1'b0;
        exeFlush = 1'b0;
        memRegWrite = 1'b0;
        memDst = '0;
        memResult = '0;
        wbRegWrite = 1'b0;
        wbDst = '0;
        wbResult = '0;
        mulDivCancel = 1'b0;
        fMemWr = 1'b0;
        fWbWr = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (r = 0; r < 3; r++) begin
            for (k = 0; k < 7; k++) begin
                issueInstr(rType(R_FUNCTS[6*k +: 6], 5'($random(seed)), 5'($random(seed)),
                                 5'($random(seed)), 5'($random(seed))),
                           $random(seed), $random(seed));
            end
            for (k = 0; k < 3; k++) begin
                issueInstr(iType(I_OPS[6*k +: 6], 5'($random(seed)), 5'($random(seed)),
                                 16'($random(seed))), $random(seed), $random(seed));
            end
        end
        issueInstr(iType(6'h3f, 5'd1, 5'd2, 16'h1234), $random(seed), $random(seed));
        issueInstr(rType(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0), $random(seed), $random(seed));

        // forwarding priority
        issueFwd(rType(6'h21, 5'd5, 5'd7, 5'd9, 5'd0), $random(seed), $random(seed),
                 1'b1, 5'd5, $random(seed), 1'b1, 5'd5, $random(seed));
        issueFwd(rType(6'h21, 5'd5, 5'd7, 5'd9, 5'd0), $random(seed), $random(seed),
                 1'b1, 5'd12, $random(seed), 1'b1, 5'd5, $random(seed));
        issueFwd(rType(6'h23, 5'd3, 5'd7, 5'd9, 5'd0), $random(seed), $random(seed),
                 1'b0, 5'd7, $random(seed), 1'b1, 5'd7, $random(seed));
        issueFwd(rType(6'h21, 5'd0, 5'd0, 5'd9, 5'd0), $random(seed), $random(seed),
                 1'b1, 5'd0, $random(seed), 1'b1, 5'd0, $random(seed));

        // branches taken and not taken
        a = $random(seed);
        issueInstr(iType(6'h04, 5'd1, 5'd2, 16'h0010), a, a);
        issueInstr(iType(6'h04, 5'd1, 5'd2, 16'hfff0), a, a ^ 32'd1);
        issueInstr(iType(6'h05, 5'd1, 5'd2, 16'hff00), a, a ^ 32'h8000_0000);
        issueInstr(iType(6'h05, 5'd1, 5'd2, 16'h0040), a, a);
        issueInstr({6'h03, 26'($random(seed))}, $random(seed), $random(seed));

        // flush and hold
        issueInstr(rType(6'h26, 5'd4, 5'd6, 5'd8, 5'd0), $random(seed), $random(seed));
        holdCycles(3);
        issueInstr(iType(6'h04, 5'd1, 5'd2, 16'h0020), a, a);
        holdCycles(3);
        flushInstr({6'h03, 26'($random(seed))});
        holdCycles(2);
        flushInstr(rType(6'h19, 5'd1, 5'd2, 5'd0, 5'd0));  // flushed multu must not start
        holdCycles(2);

        // multiply and divide
        runMulDiv(rType(6'h19, 5'd1, 5'd2, 5'd0, 5'd0), $random(seed), $random(seed), 0);
        runMulDiv(rType(6'h1b, 5'd1, 5'd2, 5'd0, 5'd0), $random(seed),
                  {16'h0, 16'($random(seed))}, 0);
        runMulDiv(rType(6'h1b, 5'd1, 5'd2, 5'd0, 5'd0), $random(seed), 32'd0, 0);
        runMulDiv(rType(6'h19, 5'd1, 5'd2, 5'd0, 5'd0), $random(seed), $random(seed), 3);
        issueInstr(rType(6'h21, 5'd1, 5'd2, 5'd3, 5'd0), $random(seed), $random(seed));
        repeat (2) @(posedge clk);

        $display("checks done, errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exeStage.f */
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/decodedBus.sv
logic/instrDecoder.sv
logic/idExeReg.sv
logic/executeUnit.sv
logic/mulDivUnit.sv
logic/exeStage.sv
testbench/exeStageTb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module exeStageTb -Mdir obj_dir -f exeStage.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VexeStageTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation did not finish cleanly"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
